// File: vlog.f
rtl/i2c_spi_pkg.sv
rtl/i2c_line_conditioner.sv
rtl/i2c_target.sv
rtl/spi_host.sv
rtl/tt_um_i2c_spi_bridge.sv
verification/tb_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the I2C to SPI bridge testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_bridge \
  -f vlog.f -o tb_bridge
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_bridge > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: verification/tb_bridge.sv
////////////////////////////////////////////////////////////////////////////
// I2C to SPI bridge testbench
// I2C controller tasks, SPI device model, predicted results per transfer
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_bridge
  import i2c_spi_pkg::*;
();

  // Predicted outcome of one write byte
  typedef struct packed {
    logic       addr_ack;
    logic       data_ack;
    logic [7:0] mosi;      // Byte the device should see
    logic [7:0] rx;        // Byte a later read returns
  } expect_t;

  logic       clk = 1'b0;
  logic       reset;
  logic       mode_bidir;         // Drives ui_in[3]
  logic       scl_drv;            // Controller SCL
  logic       sda_drv;            // Controller SDA drive (1 releases)
  logic       miso_drv = 1'b1;
  logic [7:0] spi_reply;          // Device reply byte
  logic [7:0] uo_out;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;
  logic       sda_pull;
  logic       sda_bus;
  logic       sck_q;
  logic       cs_q;
  logic [7:0] miso_shift;
  logic [7:0] mosi_shift;
  logic [7:0] mosi_log [0:63];    // MOSI byte per finished transfer
  int         xfer_count = 0;
  int         cs_low_cycles = 0;
  int         wrong_pull_cycles = 0;
  logic       tieoff_bad = 1'b0;  // Sticky, any unused output bit seen high
  int         errors = 0;
  int         err_mark = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         mark;
  logic [15:0] lfsr;
  logic [7:0]  last_rx;           // Expected read-back byte
  logic [7:0]  rnd;
  logic        ack;

  always #10 clk = ~clk;

  // Open-drain SDA with the pull from the active pin set
  assign sda_pull = mode_bidir ? uio_oe[0] : uo_out[3];
  assign sda_bus  = sda_drv & ~sda_pull;

  tt_um_i2c_spi_bridge u_tt_um_i2c_spi_bridge (
    .clk     (clk),
    .reset   (reset),
    .ui_in   ({4'b0000, mode_bidir, miso_drv, mode_bidir | scl_drv, mode_bidir | sda_bus}),
    .uio_in  ({6'b000000, ~mode_bidir | scl_drv, ~mode_bidir | sda_bus}),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  // Mode-0 SPI device model
  always @(posedge clk) begin
    sck_q <= uo_out[0];
    cs_q  <= uo_out[2];
    if (uo_out[2] !== 1'b0) begin
      miso_shift <= spi_reply;  // Preload while deselected
      miso_drv   <= spi_reply[7];
    end else if (uo_out[0] && !sck_q) begin
      mosi_shift <= {mosi_shift[6:0], uo_out[1]};  // Capture MOSI on SCK rise
    end else if (!uo_out[0] && sck_q) begin
      miso_shift <= {miso_shift[6:0], 1'b0};
      miso_drv   <= miso_shift[6];                 // Next reply bit on SCK fall
    end
    if (uo_out[2] === 1'b1 && cs_q === 1'b0) begin
      if (xfer_count < 64)
        mosi_log[xfer_count[5:0]] <= mosi_shift;
      xfer_count <= xfer_count + 1;
    end
    if (uo_out[2] === 1'b0)
      cs_low_cycles <= cs_low_cycles + 1;
    if ((mode_bidir && uo_out[3]) || (!mode_bidir && uio_oe[0]))
      wrong_pull_cycles <= wrong_pull_cycles + 1;  // Pull on the idle pin set
    if (!reset && (uio_out !== 8'h00 || uo_out[7:5] !== 3'b000 || uio_oe[7:1] !== 7'd0))
      tieoff_bad <= 1'b1;
  end

  function automatic expect_t predict_write(input logic [6:0] addr, input logic [7:0] data,
                                            input logic [7:0] reply, input logic [7:0] prev_rx);
    expect_t p;
    p.addr_ack = (addr == TARGET_ADDR);
    p.data_ack = p.addr_ack;               // Host always idle before a byte here
    p.mosi     = data;
    p.rx       = p.data_ack ? reply : prev_rx;
    return p;
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois taps 16 14 13 11
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      b    = {b[6:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("MISMATCH t=%0t %s expected %02h actual %02h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic clocks(input int n);
    repeat (n) @(posedge clk);
  endtask

  // One SCL period from low to low with SDA sampled mid high phase
  task automatic i2c_bit(input logic b, output logic seen);
    clocks(5);
    sda_drv <= b;
    clocks(5);
    scl_drv <= 1'b1;
    clocks(5);
    @(negedge clk) seen = sda_bus;
    clocks(5);
    scl_drv <= 1'b0;
  endtask

  task automatic i2c_start();
    sda_drv <= 1'b1;
    scl_drv <= 1'b1;
    clocks(10);
    sda_drv <= 1'b0;  // SDA falls with SCL high
    clocks(10);
    scl_drv <= 1'b0;
  endtask

  task automatic i2c_stop();
    clocks(5);
    sda_drv <= 1'b0;
    clocks(5);
    scl_drv <= 1'b1;
    clocks(10);
    sda_drv <= 1'b1;  // SDA rises with SCL high
    clocks(10);
  endtask

  task automatic write_byte(input logic [7:0] data, output logic acked);
    logic seen;
    for (int i = 7; i >= 0; i--)
      i2c_bit(data[i], seen);
    i2c_bit(1'b1, seen);
    acked = ~seen;  // Target pulls low to ACK
  endtask

  task automatic read_byte(input logic more, output logic [7:0] data);
    logic seen;
    for (int i = 0; i < 8; i++) begin
      i2c_bit(1'b1, seen);
      data = {data[6:0], seen};
    end
    i2c_bit(~more, seen);  // Controller ACK keeps the read going
  endtask

  task automatic wait_transfers(input int target);
    int n;
    n = 0;
    while ((xfer_count < target || uo_out[4] !== 1'b0) && n < 500) begin
      @(negedge clk);
      n++;
    end
    if (n >= 500) begin
      $display("ERROR t=%0t SPI transfer %0d did not finish in time", $time, target);
      errors++;
    end
  endtask

  // Data byte after the address and its SPI transfer
  task automatic send_data(input logic [6:0] addr, input logic [7:0] data,
                           input logic [7:0] reply);
    expect_t p;
    logic    acked;
    int      n0;
    spi_reply <= reply;
    p  = predict_write(addr, data, reply, last_rx);
    n0 = xfer_count;
    write_byte(data, acked);
    check("data_ack", 8'(p.data_ack), 8'(acked));
    if (p.data_ack) begin
      wait_transfers(n0 + 1);
      check("mosi", p.mosi, mosi_log[n0[5:0]]);
    end
    last_rx = p.rx;
  endtask

  task automatic write_txn(input logic [6:0] addr, input logic [7:0] data,
                           input logic [7:0] reply);
    expect_t p;
    logic    acked;
    p = predict_write(addr, data, reply, last_rx);
    i2c_start();
    write_byte({addr, 1'b0}, acked);
    check("addr_ack", 8'(p.addr_ack), 8'(acked));
    if (acked)
      send_data(addr, data, reply);
    i2c_stop();
  endtask

  task automatic read_txn(input int nbytes);
    logic       acked;
    logic [7:0] data;
    i2c_start();
    write_byte({TARGET_ADDR, 1'b1}, acked);
    check("read_addr_ack", 8'd1, 8'(acked));
    for (int i = 0; i < nbytes; i++) begin
      read_byte(i < nbytes - 1, data);  // NACK on the last byte
      check("read_data", last_rx, data);
    end
    i2c_stop();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
      $display("test %0d %s: FAIL", tests_run, name);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    err_mark = errors;
  endtask

  initial begin
    reset      <= 1'b1;
    mode_bidir <= 1'b0;
    scl_drv    <= 1'b1;
    sda_drv    <= 1'b1;
    spi_reply  <= 8'h00;
    lfsr    = 16'd29417;
    last_rx = 8'h00;  // rx_byte after reset
    clocks(3);
    reset <= 1'b0;
    @(negedge clk);
    check("cs_n", 8'd1, 8'(uo_out[2]));
    check("sck", 8'd0, 8'(uo_out[0]));
    check("mosi", 8'd0, 8'(uo_out[1]));
    check("busy", 8'd0, 8'(uo_out[4]));
    check("uo_out[3]", 8'd0, 8'(uo_out[3]));
    check("uio_oe[0]", 8'd0, 8'(uio_oe[0]));
    check("uio_out", 8'h00, uio_out);
    end_test("reset state");
    clocks(5);

    write_txn(TARGET_ADDR, 8'hA5, 8'hC3);
    end_test("dedicated write");

    write_txn(TARGET_ADDR, 8'h3C, 8'h5A);
    read_txn(3);
    end_test("read back");

    mark = cs_low_cycles;
    write_txn(7'h15, 8'hFF, 8'h11);
    clocks(50);
    check("cs_low_cycles", 8'd0, 8'(cs_low_cycles - mark));  // No select on a NACKed address
    end_test("address mismatch");

    mode_bidir <= 1'b1;
    clocks(10);
    mark = wrong_pull_cycles;
    write_txn(TARGET_ADDR, 8'h96, 8'hE7);
    read_txn(2);
    check("wrong_pull_cycles", 8'd0, 8'(wrong_pull_cycles - mark));
    mode_bidir <= 1'b0;
    clocks(10);
    end_test("bidirectional mode");

    i2c_start();
    write_byte({TARGET_ADDR, 1'b0}, ack);
    check("addr_ack", 8'd1, 8'(ack));
    for (int i = 0; i < 12; i++) begin
      rand_byte(rnd);
      send_data(TARGET_ADDR, rnd, 8'h81);
    end
    i2c_stop();
    check("tieoff_bad", 8'd0, 8'(tieoff_bad));  // Unused outputs over the whole run
    end_test("random stream");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: rtl/tt_um_i2c_spi_bridge.sv
////////////////////////////////////////////////////////////////////////////
// I2C to SPI bridge chip top
// Pin map, mode-pin mux between dedicated and bidirectional I2C pins
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tt_um_i2c_spi_bridge
  import i2c_spi_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] ui_in,
  input  logic [7:0] uio_in,
  output logic [7:0] uo_out,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe
);

  logic      mode_bidir;  // ui_in[3], high selects uio pins
  logic      scl_raw;
  logic      sda_raw;
  logic      sda_low;
  i2c_line_t line;
  spi_cmd_t  cmd;
  logic      spi_busy;
  logic [7:0] rx_byte;
  logic      sck;
  logic      mosi;
  logic      cs_n;

  assign mode_bidir = ui_in[3];

  // Input source select
  always_comb begin
    if (mode_bidir) begin
      sda_raw = uio_in[0];
      scl_raw = uio_in[1];
    end else begin
      sda_raw = ui_in[0];
      scl_raw = ui_in[1];
    end
  end

  i2c_line_conditioner u_i2c_line_conditioner (
    .clk     (clk),
    .reset   (reset),
    .scl_raw (scl_raw),
    .sda_raw (sda_raw),
    .line    (line)
  );

  i2c_target u_i2c_target (
    .clk      (clk),
    .reset    (reset),
    .line     (line),
    .spi_busy (spi_busy),
    .rx_byte  (rx_byte),
    .sda_low  (sda_low),
    .cmd      (cmd)
  );

  spi_host u_spi_host (
    .clk     (clk),
    .reset   (reset),
    .cmd     (cmd),
    .miso    (ui_in[2]),
    .sck     (sck),
    .mosi    (mosi),
    .cs_n    (cs_n),
    .busy    (spi_busy),
    .rx_byte (rx_byte)
  );

  // SDA pull-low goes only to the pin set the mode selects
  assign uo_out  = {3'b000, spi_busy, sda_low & ~mode_bidir, cs_n, mosi, sck};
  assign uio_out = 8'h00;  // Open drain, drive level always 0
  assign uio_oe  = {7'b0000000, sda_low & mode_bidir};

endmodule

// File: rtl/spi_host.sv
////////////////////////////////////////////////////////////////////////////
// SPI host
// One mode-0 MSB-first byte exchange per command, holds last MISO byte
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module spi_host
  import i2c_spi_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  spi_cmd_t   cmd,
  input  logic       miso,
  output logic       sck,
  output logic       mosi,
  output logic       cs_n,
  output logic       busy,
  output logic [7:0] rx_byte
);

  spi_state_t state;
  logic [3:0] half_cnt;  // clk count inside one SCK half
  logic [2:0] bit_cnt;
  logic [7:0] tx_shift;
  logic [7:0] rx_shift;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= S_IDLE;
      half_cnt <= 4'd0;
      bit_cnt  <= 3'd0;
      sck      <= 1'b0;
      mosi     <= 1'b0;
      cs_n     <= 1'b1;
      busy     <= 1'b0;
      rx_byte  <= 8'h00;
    end else begin
      case (state)
        S_IDLE: begin
          if (cmd.valid) begin
            state    <= S_SHIFT;
            cs_n     <= 1'b0;
            busy     <= 1'b1;
            half_cnt <= 4'd0;
            bit_cnt  <= 3'd0;
            tx_shift <= cmd.data;
            mosi     <= cmd.data[7];  // MSB valid before first rise
          end
        end

        S_SHIFT: begin
          if (half_cnt == SPI_HALF_CYCLES - 4'd1) begin
            half_cnt <= 4'd0;
            sck      <= ~sck;
            if (!sck) begin
              // Rising edge, sample device output
              rx_shift <= {rx_shift[6:0], miso};
            end else if (bit_cnt == 3'd7) begin
              state <= S_END;         // Last falling edge
            end else begin
              // Falling edge, present next bit
              bit_cnt  <= bit_cnt + 3'd1;
              tx_shift <= {tx_shift[6:0], 1'b0};
              mosi     <= tx_shift[6];
            end
          end else begin
            half_cnt <= half_cnt + 4'd1;
          end
        end

        S_END: begin
          state   <= S_IDLE;
          cs_n    <= 1'b1;
          busy    <= 1'b0;
          mosi    <= 1'b0;
          rx_byte <= rx_shift;        // Visible as busy drops
        end

        default: state <= S_IDLE;
      endcase
    end
  end

  // Device is selected for the whole transfer
  a_busy_selected: assert property (
    @(posedge clk) disable iff (reset)
    busy |-> !cs_n
  ) else $error("busy without chip select");

  // Mode 0 idles SCK low outside a transfer
  a_sck_idle_low: assert property (
    @(posedge clk) disable iff (reset)
    cs_n |-> !sck
  ) else $error("SCK toggling while deselected");

endmodule

// File: rtl/i2c_target.sv
////////////////////////////////////////////////////////////////////////////
// I2C target
// Address match, write bytes to SPI commands, read back the last MISO byte
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module i2c_target
  import i2c_spi_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  i2c_line_t  line,
  input  logic       spi_busy,
  input  logic [7:0] rx_byte,
  output logic       sda_low,
  output spi_cmd_t   cmd
);

  target_state_t state;
  logic [3:0]    bit_cnt;   // Bits seen in the current byte, 0..8
  logic [7:0]    shift;     // RX bits in, TX bits out
  logic          ack_flag;  // Write accept, or controller ACK on reads

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= T_IDLE;
      bit_cnt  <= 4'd0;
      sda_low  <= 1'b0;
      ack_flag <= 1'b0;
      cmd      <= '0;
    end else begin
      cmd.valid <= 1'b0;  // Strobe by default
      if (line.start) begin
        // Start or repeated start, always back to address phase
        state   <= T_ADDR;
        bit_cnt <= 4'd0;
        sda_low <= 1'b0;
      end else if (line.stop) begin
        state   <= T_IDLE;
        sda_low <= 1'b0;
      end else begin
        case (state)
          T_ADDR, T_WRITE: begin
            if (line.scl_rise) begin
              shift   <= {shift[6:0], line.sda};  // MSB first
              bit_cnt <= bit_cnt + 4'd1;
              // Buffer check on the eighth data bit
              if (state == T_WRITE && bit_cnt == 4'd7)
                ack_flag <= ~spi_busy;
            end else if (line.scl_fall && bit_cnt == 4'd8) begin
              if (state == T_ADDR) begin
                if (shift[7:1] == TARGET_ADDR) begin
                  state   <= T_ADDR_ACK;
                  sda_low <= 1'b1;     // ACK
                end else begin
                  state   <= T_IDLE;   // NACK, wait for next start
                  sda_low <= 1'b0;
                end
              end else begin
                state     <= T_WRITE_ACK;
                sda_low   <= ack_flag; // NACK drops the byte
                cmd.valid <= ack_flag;
                cmd.data  <= shift;
              end
            end
          end

          T_ADDR_ACK: begin
            if (line.scl_fall) begin
              bit_cnt <= 4'd0;
              if (shift[0]) begin
                // Read, first data bit goes out right away
                state   <= T_READ;
                shift   <= rx_byte;
                sda_low <= ~rx_byte[7];
              end else begin
                state   <= T_WRITE;
                sda_low <= 1'b0;
              end
            end
          end

          T_WRITE_ACK: begin
            if (line.scl_fall) begin
              state   <= T_WRITE;
              bit_cnt <= 4'd0;
              sda_low <= 1'b0;       // Release after ACK slot
            end
          end

          T_READ: begin
            if (line.scl_rise) begin
              bit_cnt <= bit_cnt + 4'd1;
            end else if (line.scl_fall) begin
              if (bit_cnt == 4'd8) begin
                state   <= T_READ_ACK;
                sda_low <= 1'b0;     // Controller owns the ACK slot
              end else begin
                shift   <= {shift[6:0], 1'b0};
                sda_low <= ~shift[6];  // Next bit, open drain
              end
            end
          end

          T_READ_ACK: begin
            if (line.scl_rise) begin
              ack_flag <= ~line.sda;   // Low means more bytes wanted
            end else if (line.scl_fall) begin
              bit_cnt <= 4'd0;
              if (ack_flag) begin
                // Reload, so repeated bytes give the same value
                state   <= T_READ;
                shift   <= rx_byte;
                sda_low <= ~rx_byte[7];
              end else begin
                state   <= T_IDLE;     // NACK ends the read
                sda_low <= 1'b0;
              end
            end
          end

          default: begin
            sda_low <= 1'b0;           // T_IDLE
          end
        endcase
      end
    end
  end

  // Writes are only issued into a free SPI host
  a_cmd_not_busy: assert property (
    @(posedge clk) disable iff (reset)
    !(cmd.valid && spi_busy)
  ) else $error("SPI command issued while host busy");

  // Bus stays released when not addressed
  a_idle_release: assert property (
    @(posedge clk) disable iff (reset)
    (state == T_IDLE) |-> !sda_low
  ) else $error("SDA pulled low in idle");

endmodule

// File: rtl/i2c_line_conditioner.sv
////////////////////////////////////////////////////////////////////////////
// I2C line conditioner
// Syncs SCL/SDA into clk, decodes SCL edges and start/stop conditions
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module i2c_line_conditioner
  import i2c_spi_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      scl_raw,
  input  logic      sda_raw,
  output i2c_line_t line
);

  logic [1:0] scl_sync;  // [0] meta stage, [1] usable
  logic [1:0] sda_sync;
  logic       scl_prev;  // History for edge decode
  logic       sda_prev;

  // Sync and history start at the idle-high bus level
  always_ff @(posedge clk) begin
    if (reset) begin
      scl_sync <= 2'b11;
      sda_sync <= 2'b11;
      scl_prev <= 1'b1;
      sda_prev <= 1'b1;
    end else begin
      scl_sync <= {scl_sync[0], scl_raw};
      sda_sync <= {sda_sync[0], sda_raw};
      scl_prev <= scl_sync[1];
      sda_prev <= sda_sync[1];
    end
  end

  // One-cycle event pulses
  always_comb begin
    line.scl      = scl_sync[1];
    line.sda      = sda_sync[1];
    line.scl_rise = scl_sync[1] & ~scl_prev;
    line.scl_fall = ~scl_sync[1] & scl_prev;
    // SCL must be high both before and after the SDA change
    line.start    = scl_sync[1] & scl_prev & sda_prev & ~sda_sync[1];
    line.stop     = scl_sync[1] & scl_prev & ~sda_prev & sda_sync[1];
  end

  // SDA and SCL never move on the same sample, start/stop decode needs them apart
  a_sda_scl_apart: assert property (
    @(posedge clk) disable iff (reset)
    !((scl_sync[1] ^ scl_prev) && (sda_sync[1] ^ sda_prev))
  ) else $error("SDA and SCL changed in the same cycle");

endmodule

// File: rtl/i2c_spi_pkg.sv
////////////////////////////////////////////////////////////////////////////
// I2C to SPI bridge shared definitions
// Bus address, SPI timing, line events, SPI command and state encodings
////////////////////////////////////////////////////////////////////////////
package i2c_spi_pkg;

  // 7-bit target address on the I2C bus
  localparam logic [6:0] TARGET_ADDR = 7'h2A;

  // clk cycles per SCK half period
  localparam logic [3:0] SPI_HALF_CYCLES = 4'd2;

  // Synchronized bus view, the last four fields are one-cycle pulses
  typedef struct packed {
    logic scl;       // Synced SCL level
    logic sda;       // Synced SDA level
    logic scl_rise;
    logic scl_fall;
    logic start;     // SDA fall with SCL high
    logic stop;      // SDA rise with SCL high
  } i2c_line_t;

  // One byte handed to the SPI host
  typedef struct packed {
    logic       valid;  // Single-cycle strobe
    logic [7:0] data;
  } spi_cmd_t;

  // I2C target FSM
  typedef enum logic [2:0] {
    T_IDLE,
    T_ADDR,       // Shifting in address + R/W
    T_ADDR_ACK,
    T_WRITE,      // Shifting in a data byte
    T_WRITE_ACK,
    T_READ,       // Shifting out rx_byte
    T_READ_ACK    // Controller ACK/NACK slot
  } target_state_t;

  // SPI host FSM
  typedef enum logic [1:0] {
    S_IDLE,
    S_SHIFT,
    S_END
  } spi_state_t;

endpackage
